//--- test/dcache_vectors.txt
// columns: op size address store_value expected_load_value, all hex
// op 0 load, 1 store, 2 load that must hit at once; size 0 byte, 1 half, 2 word
0 2 0100 00000000 00000000
1 2 0100 deadbeef 00000000
0 2 0100 00000000 deadbeef
0 2 0104 00000000 00000000
1 0 0101 000000a5 00000000
1 1 0106 00001234 00000000
0 2 0100 00000000 deada5ef
0 0 0103 00000000 000000de
0 1 0102 00000000 0000dead
0 1 0106 00000000 00001234
2 0 0101 00000000 000000a5
1 2 0208 cafef00d 00000000
0 0 020b 00000000 000000ca
1 2 0300 11111111 00000000
1 2 0400 22222222 00000000
1 2 0500 33333333 00000000
1 2 0600 44444444 00000000
1 2 0700 55555555 00000000
1 2 0800 66666666 00000000
1 2 0900 77777777 00000000
1 2 0a00 88888888 00000000
0 2 0100 00000000 deada5ef
0 2 0104 00000000 12340000
0 2 0208 00000000 cafef00d
0 2 0300 00000000 11111111
2 2 0300 00000000 11111111
0 0 0902 00000000 00000077

//--- dcache_system.f
source/mem_bus_pkg.sv
source/dcache_pkg.sv
source/mem_bus_if.sv
source/dcache_array.sv
source/miss_table.sv
source/tagged_memory.sv
source/dcache_system.sv
test/dcache_checker.sv
test/dcache_system_tb.sv

//--- Bender.yml
package:
  name: dcache_system

sources:
  - files:
      - source/mem_bus_pkg.sv
      - source/dcache_pkg.sv
      - source/mem_bus_if.sv
      - source/dcache_array.sv
      - source/miss_table.sv
      - source/tagged_memory.sv
      - source/dcache_system.sv
  - target: test
    files:
      - test/dcache_checker.sv
      - test/dcache_system_tb.sv

//--- test/dcache_system_tb.sv
/*
 * testbench for the data cache subsystem, replaying loads and
 * stores from a vector file until the cache completes them
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_system_tb;

    localparam int MAX_VECTORS  = 64;
    localparam int FIELDS       = 5;
    localparam int REPLAY_LIMIT = 200;

    logic                       clock;
    logic                       reset;
    logic                       load_valid;
    mem_bus_pkg::byte_addr_t    load_addr;
    dcache_pkg::mem_size_t      load_size;
    logic                       load_done;
    dcache_pkg::word_t          load_value;
    logic                       store_valid;
    mem_bus_pkg::byte_addr_t    store_addr;
    dcache_pkg::mem_size_t      store_size;
    dcache_pkg::word_t          store_value;
    logic                       store_done;

    dcache_pkg::word_t          expected_value;
    logic                       must_hit;
    int                         test_index;
    int                         test_count;
    int                         error_count;
    int                         timeouts;

    // op, size, address, store value, expected load value
    logic [31:0] vectors [MAX_VECTORS*FIELDS];

    dcache_system DUT (
        .clock       (clock),
        .reset       (reset),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_size   (load_size),
        .load_done   (load_done),
        .load_value  (load_value),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_size  (store_size),
        .store_value (store_value),
        .store_done  (store_done)
    );

    dcache_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .load_valid     (load_valid),
        .load_done      (load_done),
        .load_value     (load_value),
        .store_valid    (store_valid),
        .store_done     (store_done),
        .expected_value (expected_value),
        .must_hit       (must_hit),
        .test_index     (test_index),
        .test_count     (test_count),
        .error_count    (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // one access, presented again every cycle until done
    ////////////////////////////////////////////////////////////

    task automatic run_access(input int v);
        logic [31:0]    op;
        logic [31:0]    size_field;
        logic [31:0]    addr_field;
        int             cycles;
        logic           done;
        op         = vectors[v*FIELDS];
        size_field = vectors[v*FIELDS+1];
        addr_field = vectors[v*FIELDS+2];
        test_index     = v;
        expected_value = vectors[v*FIELDS+4];
        must_hit       = op == 32'd2;
        if (op == 32'd1) begin
            store_addr  = addr_field[15:0];
            store_size  = dcache_pkg::mem_size_t'(size_field[1:0]);
            store_value = vectors[v*FIELDS+3];
            store_valid = 1'b1;
        end else begin
            load_addr  = addr_field[15:0];
            load_size  = dcache_pkg::mem_size_t'(size_field[1:0]);
            load_valid = 1'b1;
        end
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < REPLAY_LIMIT) begin
            @(posedge clock);
            done = op == 32'd1 ? store_done : load_done;
            cycles++;
        end
        @(negedge clock);
        load_valid  = 1'b0;
        store_valid = 1'b0;
        if (!done) begin
            $display("vector %0d was not completed within %0d cycles", v, REPLAY_LIMIT);
            timeouts++;
        end
    endtask

    initial begin
        int n;
        int gap;
        int seed_value;
        seed_value = $urandom(32'h922e_1cc0);
        reset          = 1'b1;
        load_valid     = 1'b0;
        load_addr      = '0;
        load_size      = dcache_pkg::BYTE;
        store_valid    = 1'b0;
        store_addr     = '0;
        store_size     = dcache_pkg::BYTE;
        store_value    = '0;
        expected_value = '0;
        must_hit       = 1'b0;
        test_index     = 0;
        timeouts       = 0;
        $readmemh("test/dcache_vectors.txt", vectors);

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // idle cycles, done strobes must stay low
        repeat (4) @(negedge clock);

        n = 0;
        while (n < MAX_VECTORS && !$isunknown(vectors[n*FIELDS]) && timeouts == 0) begin
            // no gap before a load that must hit at once
            if (vectors[n*FIELDS] != 32'd2) begin
                gap = $urandom % 4;
                repeat (gap) @(negedge clock);
            end
            run_access(n);
            n++;
        end
        @(negedge clock);

        if (n == 0) begin
            $display("no vectors were read from the vector file");
        end
        $display("%0d of %0d tests finished, %0d errors, %0d timeouts",
                 test_count, n, error_count, timeouts);
        if (n > 0 && test_count == n && error_count == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dcache_checker.sv
/*
 * dcache checker: watches the load and store ports of the cache,
 * compares load values and reports each finished access
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_checker (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     load_valid,
    input  wire                     load_done,
    input  wire dcache_pkg::word_t  load_value,
    input  wire                     store_valid,
    input  wire                     store_done,
    input  wire dcache_pkg::word_t  expected_value,
    input  wire                     must_hit,
    input  int                      test_index,
    output int                      test_count,
    output int                      error_count
);

    int     wait_cycles;
    int     errors_now;
    logic   bad;

    always @(posedge clock) begin
        if (reset) begin
            test_count  <= 0;
            error_count <= 0;
            wait_cycles <= 0;
        end else begin
            errors_now = 0;
            // done strobes must stay low without a request
            if (load_done && !load_valid) begin
                $display("load_done rose at %0t ns with no load presented", $time);
                errors_now++;
            end
            if (store_done && !store_valid) begin
                $display("store_done rose at %0t ns with no store presented", $time);
                errors_now++;
            end

            if (load_valid && load_done) begin
                bad = 1'b0;
                if (load_value !== expected_value) begin
                    $display("error at %0t ns: load_value is %h, expected %h",
                             $time, load_value, expected_value);
                    bad = 1'b1;
                end
                if (must_hit && wait_cycles != 0) begin
                    $display("load of test %0d did not hit when first presented", test_index);
                    bad = 1'b1;
                end
                $display("test %0d load %s after %0d replays", test_index,
                         bad ? "mismatch" : "ok", wait_cycles);
                errors_now += int'(bad);
                test_count  <= test_count + 1;
                wait_cycles <= 0;
            end else if (store_valid && store_done) begin
                $display("test %0d store ok after %0d replays", test_index, wait_cycles);
                test_count  <= test_count + 1;
                wait_cycles <= 0;
            end else if (load_valid || store_valid) begin
                wait_cycles <= wait_cycles + 1;
            end
            error_count <= error_count + errors_now;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_system.sv
/*
 * write-through data cache subsystem with its miss table and
 * tagged backing memory
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_system (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            load_valid,
    input  wire mem_bus_pkg::byte_addr_t   load_addr,
    input  wire dcache_pkg::mem_size_t     load_size,
    output logic                           load_done,
    output dcache_pkg::word_t              load_value,
    input  wire                            store_valid,
    input  wire mem_bus_pkg::byte_addr_t   store_addr,
    input  wire dcache_pkg::mem_size_t     store_size,
    input  wire dcache_pkg::word_t         store_value,
    output logic                           store_done
);

    mem_bus_if bus ();
    fill_if    fill ();
    alloc_if   alloc ();

    dcache_array u_array (
        .clock       (clock),
        .reset       (reset),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_size   (load_size),
        .load_done   (load_done),
        .load_value  (load_value),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_size  (store_size),
        .store_value (store_value),
        .store_done  (store_done),
        .fill        (fill.receiver),
        .alloc       (alloc.requester)
    );

    miss_table u_miss_table (
        .clock (clock),
        .reset (reset),
        .alloc (alloc.owner),
        .fill  (fill.sender),
        .bus   (bus.requester)
    );

    tagged_memory u_memory (
        .clock (clock),
        .reset (reset),
        .bus   (bus.responder)
    );

endmodule

`default_nettype wire

//--- source/tagged_memory.sv
/*
 * block memory answering tagged requests after a fixed latency,
 * with several responses in flight at once
 */
`timescale 1ns/1ns
`default_nettype none

module tagged_memory (
    input  wire          clock,
    input  wire          reset,
    mem_bus_if.responder bus
);

    localparam int LAST = mem_bus_pkg::MEM_LATENCY - 1;

    mem_bus_pkg::block_t mem_q [mem_bus_pkg::MEM_BLOCKS];

    logic [mem_bus_pkg::TAG_COUNT:0]                            busy_q;
    mem_bus_pkg::mem_tag_t                                      next_tag_q;
    logic [LAST:0]                                              pipe_valid_q;
    mem_bus_pkg::mem_tag_t [LAST:0]                             pipe_tag_q;
    mem_bus_pkg::block_t [LAST:0]                               pipe_data_q;

    mem_bus_pkg::mem_tag_t                      grant_tag;
    int                                         cand;
    logic                                       accept;
    logic [mem_bus_pkg::MEM_INDEX_BITS-1:0]     index;
    mem_bus_pkg::block_t                        read_data;

    // first idle tag at or after the counter, wrapping past zero
    always_comb begin
        grant_tag = '0;
        cand      = 0;
        for (int k = 0; k < mem_bus_pkg::TAG_COUNT; k++) begin
            cand = (int'(next_tag_q) - 1 + k) % mem_bus_pkg::TAG_COUNT + 1;
            if (grant_tag == '0 && !busy_q[cand]) begin
                grant_tag = mem_bus_pkg::mem_tag_t'(cand);
            end
        end
    end

    assign accept       = bus.request_valid && grant_tag != '0;
    assign bus.response = bus.request_valid ? grant_tag : '0;
    assign index        = bus.address[mem_bus_pkg::MEM_INDEX_BITS+2:3];
    assign read_data    = bus.command == mem_bus_pkg::BUS_STORE ? bus.write_data : mem_q[index];

    assign bus.response_valid = pipe_valid_q[LAST];
    assign bus.response_tag   = pipe_tag_q[LAST];
    assign bus.response_data  = pipe_data_q[LAST];

    // writes land at acceptance, so later fetches see them
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int b = 0; b < mem_bus_pkg::MEM_BLOCKS; b++) begin
                mem_q[b] <= '0;
            end
        end else if (accept && bus.command == mem_bus_pkg::BUS_STORE) begin
            mem_q[index] <= bus.write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q       <= '0;
            next_tag_q   <= mem_bus_pkg::mem_tag_t'(1);
            pipe_valid_q <= '0;
        end else begin
            pipe_valid_q <= {pipe_valid_q[LAST-1:0], accept};
            if (pipe_valid_q[LAST]) begin
                busy_q[pipe_tag_q[LAST]] <= 1'b0;
            end
            if (accept) begin
                busy_q[grant_tag] <= 1'b1;
                next_tag_q <= grant_tag == mem_bus_pkg::mem_tag_t'(mem_bus_pkg::TAG_COUNT)
                              ? mem_bus_pkg::mem_tag_t'(1) : grant_tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        pipe_tag_q  <= {pipe_tag_q[LAST-1:0], grant_tag};
        pipe_data_q <= {pipe_data_q[LAST-1:0], read_data};
    end

endmodule

`default_nettype wire

//--- source/miss_table.sv
/*
 * miss table: outstanding fetches and write-throughs, issued one per
 * cycle to the tagged memory and retired on a matching response tag
 */
`timescale 1ns/1ns
`default_nettype none

module miss_table (
    input  wire         clock,
    input  wire         reset,
    alloc_if.owner      alloc,
    fill_if.sender      fill,
    mem_bus_if.requester bus
);

    logic [dcache_pkg::MISS_LINES-1:0]                          valid_q;
    logic [dcache_pkg::MISS_LINES-1:0]                          sent_q;
    mem_bus_pkg::mem_tag_t [dcache_pkg::MISS_LINES-1:0]         tag_q;
    mem_bus_pkg::block_addr_t [dcache_pkg::MISS_LINES-1:0]      addr_q;
    mem_bus_pkg::block_t [dcache_pkg::MISS_LINES-1:0]           data_q;
    dcache_pkg::miss_op_t [dcache_pkg::MISS_LINES-1:0]          op_q;

    logic   retire_hit;
    int     retire_idx;
    logic   issue_hit;
    int     issue_idx;
    logic   accepted;
    int     free_idx;

    always_comb begin
        retire_hit = 1'b0;
        retire_idx = 0;
        issue_hit  = 1'b0;
        issue_idx  = 0;
        alloc.alloc_free    = 1'b0;
        alloc.alloc_pending = 1'b0;
        free_idx   = 0;
        for (int i = 0; i < dcache_pkg::MISS_LINES; i++) begin
            if (bus.response_valid && valid_q[i] && sent_q[i]
                    && tag_q[i] == bus.response_tag) begin
                retire_hit = 1'b1;
                retire_idx = i;
            end
            // lowest unsent entry goes out first
            if (!issue_hit && valid_q[i] && !sent_q[i]) begin
                issue_hit = 1'b1;
                issue_idx = i;
            end
            if (!alloc.alloc_free && !valid_q[i]) begin
                alloc.alloc_free = 1'b1;
                free_idx         = i;
            end
            if (valid_q[i] && addr_q[i] == alloc.alloc_block_addr) begin
                alloc.alloc_pending = 1'b1;
            end
        end
    end

    // fetch responses go straight into the cache lines
    assign fill.fill_valid      = retire_hit && op_q[retire_idx] != dcache_pkg::OP_WRITE_THROUGH;
    assign fill.fill_block_addr = addr_q[retire_idx];
    assign fill.fill_data       = bus.response_data;

    assign bus.request_valid = issue_hit;
    assign bus.address       = {addr_q[issue_idx], 3'b000};
    assign bus.write_data    = data_q[issue_idx];
    assign accepted          = issue_hit && bus.response != '0;

    always_comb begin
        if (!issue_hit) begin
            bus.command = mem_bus_pkg::BUS_NONE;
        end else if (op_q[issue_idx] == dcache_pkg::OP_WRITE_THROUGH) begin
            bus.command = mem_bus_pkg::BUS_STORE;
        end else begin
            bus.command = mem_bus_pkg::BUS_LOAD;
        end
    end

    ////////////////////////////////////////////////////////////
    // entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            sent_q  <= '0;
        end else begin
            if (retire_hit) begin
                valid_q[retire_idx] <= 1'b0;
            end
            if (accepted) begin
                sent_q[issue_idx] <= 1'b1;
            end
            // a free slot is never the retiring or the issuing one
            if (alloc.alloc_valid && alloc.alloc_free) begin
                valid_q[free_idx] <= 1'b1;
                sent_q[free_idx]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) begin
            tag_q[issue_idx] <= bus.response;
        end
        if (alloc.alloc_valid && alloc.alloc_free) begin
            addr_q[free_idx] <= alloc.alloc_block_addr;
            data_q[free_idx] <= alloc.alloc_data;
            op_q[free_idx]   <= alloc.alloc_op;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_array.sv
/*
 * fully associative write-through cache lines with lru ordering,
 * same-cycle load hits and store merging into the hit line
 */
`timescale 1ns/1ns
`default_nettype none

module dcache_array (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            load_valid,
    input  wire mem_bus_pkg::byte_addr_t   load_addr,
    input  wire dcache_pkg::mem_size_t     load_size,
    output logic                           load_done,
    output dcache_pkg::word_t              load_value,
    input  wire                            store_valid,
    input  wire mem_bus_pkg::byte_addr_t   store_addr,
    input  wire dcache_pkg::mem_size_t     store_size,
    input  wire dcache_pkg::word_t         store_value,
    output logic                           store_done,
    fill_if.receiver                       fill,
    alloc_if.requester                     alloc
);

    logic [dcache_pkg::CACHE_LINES-1:0]                             valid_q, valid_d;
    mem_bus_pkg::block_addr_t [dcache_pkg::CACHE_LINES-1:0]         addr_q, addr_d;
    mem_bus_pkg::block_t [dcache_pkg::CACHE_LINES-1:0]              data_q, data_d;
    dcache_pkg::lru_set_t                                           lru_q, lru_d;

    int                     victim;
    int                     load_line;
    int                     store_line;
    logic                   load_hit;
    logic                   store_hit;
    mem_bus_pkg::block_t    merged;

    // move one line to the top, lines above its old count age by one
    function automatic dcache_pkg::lru_set_t promote(dcache_pkg::lru_set_t lru, int line);
        dcache_pkg::lru_set_t aged;
        dcache_pkg::lru_t     old;
        aged       = lru;
        old        = lru[line];
        aged[line] = dcache_pkg::lru_t'(dcache_pkg::CACHE_LINES);
        for (int i = 0; i < dcache_pkg::CACHE_LINES; i++) begin
            if (aged[i] > old) begin
                aged[i] = aged[i] - 1'b1;
            end
        end
        return aged;
    endfunction

    ////////////////////////////////////////////////////////////
    // fill, lookup, merge
    ////////////////////////////////////////////////////////////

    always_comb begin
        valid_d = valid_q;
        addr_d  = addr_q;
        data_d  = data_q;
        lru_d   = lru_q;

        // fill goes to the lowest line with a zero counter
        victim = 0;
        for (int i = dcache_pkg::CACHE_LINES - 1; i >= 0; i--) begin
            if (lru_q[i] == '0) begin
                victim = i;
            end
        end
        if (fill.fill_valid) begin
            valid_d[victim] = 1'b1;
            addr_d[victim]  = fill.fill_block_addr;
            data_d[victim]  = fill.fill_data;
            lru_d           = promote(lru_d, victim);
        end

        // both ports look up against the post-fill lines
        load_hit   = 1'b0;
        load_line  = 0;
        store_hit  = 1'b0;
        store_line = 0;
        for (int i = 0; i < dcache_pkg::CACHE_LINES; i++) begin
            if (valid_d[i] && addr_d[i] == load_addr[15:3]) begin
                load_hit  = 1'b1;
                load_line = i;
            end
            if (valid_d[i] && addr_d[i] == store_addr[15:3]) begin
                store_hit  = 1'b1;
                store_line = i;
            end
        end

        // zero-extended field picked by the low address bits
        case (load_size)
            dcache_pkg::BYTE:
                load_value = {24'b0, data_d[load_line][{load_addr[2:0], 3'b000} +: 8]};
            dcache_pkg::HALF:
                load_value = {16'b0, data_d[load_line][{load_addr[2:1], 4'b0000} +: 16]};
            default:
                load_value = data_d[load_line][{load_addr[2], 5'b00000} +: 32];
        endcase
        load_done = load_valid && load_hit;
        if (load_done) begin
            lru_d = promote(lru_d, load_line);
        end

        merged = data_d[store_line];
        case (store_size)
            dcache_pkg::BYTE: merged[{store_addr[2:0], 3'b000} +: 8]   = store_value[7:0];
            dcache_pkg::HALF: merged[{store_addr[2:1], 4'b0000} +: 16] = store_value[15:0];
            default:          merged[{store_addr[2], 5'b00000} +: 32]  = store_value;
        endcase

        // store and load misses share the one allocation port, store first
        alloc.alloc_valid = 1'b0;
        alloc.alloc_op    = dcache_pkg::OP_LOAD_FETCH;
        store_done        = 1'b0;
        if (store_valid) begin
            if (store_hit) begin
                lru_d             = promote(lru_d, store_line);
                alloc.alloc_op    = dcache_pkg::OP_WRITE_THROUGH;
                alloc.alloc_valid = alloc.alloc_free;
                store_done        = alloc.alloc_free;
                if (alloc.alloc_free) begin
                    data_d[store_line] = merged;
                end
            end else begin
                alloc.alloc_op    = dcache_pkg::OP_STORE_FETCH;
                alloc.alloc_valid = !alloc.alloc_pending && alloc.alloc_free;
            end
        end else if (load_valid && !load_hit) begin
            alloc.alloc_valid = !alloc.alloc_pending && alloc.alloc_free;
        end
    end

    assign alloc.alloc_block_addr = store_valid ? store_addr[15:3] : load_addr[15:3];
    assign alloc.alloc_data       = merged;

    ////////////////////////////////////////////////////////////
    // line state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            valid_q <= valid_d;
            lru_q   <= lru_d;
        end
    end

    always_ff @(posedge clock) begin
        addr_q <= addr_d;
        data_q <= data_d;
    end

endmodule

`default_nettype wire

//--- source/mem_bus_if.sv
/*
 * connections inside the cache subsystem: the tagged memory bus,
 * the line fill path and the miss table allocation port
 */
`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if;
    logic                       request_valid;
    mem_bus_pkg::bus_command_t  command;
    mem_bus_pkg::byte_addr_t    address;
    mem_bus_pkg::block_t        write_data;
    // nonzero tag when accepted, same cycle as the request
    mem_bus_pkg::mem_tag_t      response;
    logic                       response_valid;
    mem_bus_pkg::mem_tag_t      response_tag;
    mem_bus_pkg::block_t        response_data;

    modport requester (
        output request_valid, command, address, write_data,
        input  response, response_valid, response_tag, response_data
    );
    modport responder (
        input  request_valid, command, address, write_data,
        output response, response_valid, response_tag, response_data
    );
endinterface

interface fill_if;
    logic                       fill_valid;
    mem_bus_pkg::block_addr_t   fill_block_addr;
    mem_bus_pkg::block_t        fill_data;

    modport sender   (output fill_valid, fill_block_addr, fill_data);
    modport receiver (input  fill_valid, fill_block_addr, fill_data);
endinterface

interface alloc_if;
    logic                       alloc_valid;
    dcache_pkg::miss_op_t       alloc_op;
    mem_bus_pkg::block_addr_t   alloc_block_addr;
    mem_bus_pkg::block_t        alloc_data;
    logic                       alloc_pending;
    logic                       alloc_free;

    modport requester (
        output alloc_valid, alloc_op, alloc_block_addr, alloc_data,
        input  alloc_pending, alloc_free
    );
    modport owner (
        input  alloc_valid, alloc_op, alloc_block_addr, alloc_data,
        output alloc_pending, alloc_free
    );
endinterface

`default_nettype wire

//--- source/dcache_pkg.sv
/*
 * data cache definitions: access sizes, cache and miss table
 * sizes, lru counters and miss table operations
 */
`default_nettype none

package dcache_pkg;

    localparam int CACHE_LINES = 8;
    localparam int MISS_LINES  = 4;
    localparam int LRU_BITS    = 4;
    localparam int WORD_BITS   = 32;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_t;

    // mru line reaches CACHE_LINES, the victim sits at zero
    typedef logic [LRU_BITS-1:0] lru_t;
    typedef lru_t [CACHE_LINES-1:0] lru_set_t;

    typedef logic [WORD_BITS-1:0] word_t;

    typedef enum logic [1:0] {
        OP_LOAD_FETCH    = 2'b00,
        OP_STORE_FETCH   = 2'b01,
        OP_WRITE_THROUGH = 2'b10
    } miss_op_t;

endpackage

`default_nettype wire

//--- source/mem_bus_pkg.sv
/*
 * memory bus definitions: address, block and tag types, bus commands,
 * and the geometry and latency of the tagged block memory
 */
`default_nettype none

package mem_bus_pkg;

    localparam int ADDR_BITS      = 16;
    localparam int BLOCK_BITS     = 64;
    localparam int TAG_BITS       = 4;
    // tag zero is reserved for a refused request
    localparam int TAG_COUNT      = 2 ** TAG_BITS - 1;
    localparam int MEM_LATENCY    = 4;
    localparam int MEM_BLOCKS     = 1024;
    localparam int MEM_INDEX_BITS = $clog2(MEM_BLOCKS);

    typedef logic [ADDR_BITS-1:0] byte_addr_t;
    // byte address without the 3 offset bits
    typedef logic [ADDR_BITS-4:0] block_addr_t;
    typedef logic [BLOCK_BITS-1:0] block_t;
    typedef logic [TAG_BITS-1:0] mem_tag_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'b00,
        BUS_LOAD  = 2'b01,
        BUS_STORE = 2'b10
    } bus_command_t;

endpackage

`default_nettype wire
